// File: source/basicTypes.sv
// basicTypes package: word, address, instruction and register index types
package basicTypes;

  localparam int dataWidth    = 32;
  localparam int regAddrWidth = 5;

  // plain data word, as carried on register reads and the writeback port
  typedef logic [dataWidth-1:0] BasicData;

  // byte address, also used for the pc
  typedef logic [dataWidth-1:0] Addr;

  // raw instruction word from the instruction memory
  typedef logic [dataWidth-1:0] Inst;

  // register index, x0 to x31
  typedef logic [regAddrWidth-1:0] RegAddr;

endpackage

// File: source/pipelineTypes.sv
// pipelineTypes package: queue sizing, credit type and decode enums
package pipelineTypes;

  localparam int queueDepth    = 4;                      // power of two
  localparam int creditWidth   = $clog2(queueDepth + 1); // counts 0 to queueDepth
  localparam int queuePtrWidth = $clog2(queueDepth);

  typedef logic [creditWidth-1:0]   Credit;
  typedef logic [queuePtrWidth-1:0] QueuePtr;

  typedef enum logic [6:0] {
    opcLui    = 7'b0110111,
    opcAuipc  = 7'b0010111,
    opcJal    = 7'b1101111,
    opcOp     = 7'b0110011,
    opcOpImm  = 7'b0010011,
    opcLoad   = 7'b0000011,
    opcStore  = 7'b0100011,
    opcBranch = 7'b1100011
  } OpCode;

  typedef enum logic [3:0] {
    aluAdd,
    aluSub,
    aluSll,
    aluSlt,
    aluSltu,
    aluXor,
    aluSrl,
    aluSra,
    aluOr,
    aluAnd,
    aluPassB, // lui, passes the immediate
    aluNone
  } AluOp;

  // second alu operand
  typedef enum logic {
    srcReg,
    srcImm
  } AluSrc;

  typedef enum logic [2:0] {
    immI,
    immS,
    immB,
    immU,
    immJ,
    immNone
  } ImmType;

endpackage

// File: source/fetchUnit.sv
// fetchUnit: pc register, credit counter and push into the instruction queue
`timescale 1ns/1ps

module fetchUnit (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  redirectValid,
  input  basicTypes::Addr       redirectPc,
  output basicTypes::Addr       imemAddr,
  input  basicTypes::Inst       imemData,
  input  pipelineTypes::Credit  creditReturn,
  output logic                  pushValid,
  output basicTypes::Addr       pushPc,
  output basicTypes::Inst       pushInst
);

  basicTypes::Addr      pc;
  pipelineTypes::Credit credits; // free queue slots as seen from fetch

  assign imemAddr = pc;

  // memory answers in the same cycle, so the word is pushed right away
  assign pushValid = (credits != '0) && !redirectValid;
  assign pushPc    = pc;
  assign pushInst  = imemData;

  always_ff @(posedge clk) begin
    if (!rstN) begin
      pc <= '0;
    end else if (redirectValid) begin
      pc <= redirectPc;
    end else if (pushValid) begin
      pc <= pc + 32'd4;
    end
  end

  // returned credits come back one cycle after the pop or flush
  always_ff @(posedge clk) begin
    if (!rstN) begin
      credits <= pipelineTypes::Credit'(pipelineTypes::queueDepth);
    end else begin
      credits <= credits + creditReturn - pipelineTypes::Credit'(pushValid);
    end
  end

endmodule

// File: source/instQueue.sv
// instQueue: circular buffer of pc and instruction pairs with credit return
`timescale 1ns/1ps

module instQueue (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  redirectValid,
  input  logic                  pushValid,
  input  basicTypes::Addr       pushPc,
  input  basicTypes::Inst       pushInst,
  input  logic                  pop,
  output pipelineTypes::Credit  creditReturn,
  output logic                  headValid,
  output basicTypes::Addr       headPc,
  output basicTypes::Inst       headInst
);

  basicTypes::Addr        pcMem   [pipelineTypes::queueDepth];
  basicTypes::Inst        instMem [pipelineTypes::queueDepth];
  pipelineTypes::QueuePtr rdPtr;
  pipelineTypes::QueuePtr wrPtr;
  pipelineTypes::Credit   count;
  logic                   doPush;
  logic                   doPop;

  assign doPush = pushValid && !redirectValid; // a push during a flush is dropped
  assign doPop  = pop && headValid && !redirectValid;

  assign headValid = (count != '0);
  assign headPc    = pcMem[rdPtr];
  assign headInst  = instMem[rdPtr];

  // flush hands back every held slot plus the dropped push
  always_comb begin
    if (redirectValid) begin
      creditReturn = count + pipelineTypes::Credit'(pushValid);
    end else begin
      creditReturn = pipelineTypes::Credit'(doPop);
    end
  end

  always_ff @(posedge clk) begin
    if (doPush) begin
      pcMem[wrPtr]   <= pushPc;
      instMem[wrPtr] <= pushInst;
    end
  end

  // pointers wrap naturally since the depth is a power of two
  always_ff @(posedge clk) begin
    if (!rstN || redirectValid) begin
      rdPtr <= '0;
      wrPtr <= '0;
      count <= '0;
    end else begin
      if (doPush) begin
        wrPtr <= wrPtr + 1'b1;
      end
      if (doPop) begin
        rdPtr <= rdPtr + 1'b1;
      end
      count <= count + pipelineTypes::Credit'(doPush) - pipelineTypes::Credit'(doPop);
    end
  end

endmodule

// File: source/decoder.sv
// decoder: RV32I field extraction, immediate build and control decode
`timescale 1ns/1ps

module decoder (
  input  basicTypes::Inst       inst,
  output basicTypes::RegAddr    rs1Addr,
  output basicTypes::RegAddr    rs2Addr,
  output basicTypes::RegAddr    rdAddr,
  output basicTypes::BasicData  imm,
  output pipelineTypes::AluOp   aluOp,
  output pipelineTypes::AluSrc  aluSrc,
  output logic                  isLoad,
  output logic                  isStore,
  output logic                  isBranch,
  output logic                  isJump,
  output logic                  writesRd,
  output logic                  isIllegal
);

  pipelineTypes::OpCode  opcode;
  pipelineTypes::ImmType immType;
  logic [2:0]            funct3;
  logic [6:0]            funct7;
  logic                  legal;

  // shared by OP and OP-IMM, alt is instruction bit 30
  function automatic pipelineTypes::AluOp functToAlu(input logic [2:0] f3, input logic alt);
    case (f3)
      3'b000:  functToAlu = alt ? pipelineTypes::aluSub : pipelineTypes::aluAdd;
      3'b001:  functToAlu = pipelineTypes::aluSll;
      3'b010:  functToAlu = pipelineTypes::aluSlt;
      3'b011:  functToAlu = pipelineTypes::aluSltu;
      3'b100:  functToAlu = pipelineTypes::aluXor;
      3'b101:  functToAlu = alt ? pipelineTypes::aluSra : pipelineTypes::aluSrl;
      3'b110:  functToAlu = pipelineTypes::aluOr;
      default: functToAlu = pipelineTypes::aluAnd;
    endcase
  endfunction

  assign opcode  = pipelineTypes::OpCode'(inst[6:0]);
  assign funct3  = inst[14:12];
  assign funct7  = inst[31:25];
  assign rdAddr  = inst[11:7];
  assign rs1Addr = inst[19:15];
  assign rs2Addr = inst[24:20];

  always_comb begin
    aluOp    = pipelineTypes::aluNone;
    aluSrc   = pipelineTypes::srcReg;
    immType  = pipelineTypes::immNone;
    isLoad   = 1'b0;
    isStore  = 1'b0;
    isBranch = 1'b0;
    isJump   = 1'b0;
    writesRd = 1'b0;
    legal    = 1'b1;
    case (opcode)
      pipelineTypes::opcLui: begin
        aluOp    = pipelineTypes::aluPassB;
        aluSrc   = pipelineTypes::srcImm;
        immType  = pipelineTypes::immU;
        writesRd = 1'b1;
      end
      pipelineTypes::opcAuipc: begin
        aluOp    = pipelineTypes::aluAdd; // pc + imm
        aluSrc   = pipelineTypes::srcImm;
        immType  = pipelineTypes::immU;
        writesRd = 1'b1;
      end
      pipelineTypes::opcJal: begin
        aluOp    = pipelineTypes::aluAdd;
        aluSrc   = pipelineTypes::srcImm;
        immType  = pipelineTypes::immJ;
        isJump   = 1'b1;
        writesRd = 1'b1;
      end
      pipelineTypes::opcOp: begin
        aluOp    = functToAlu(funct3, inst[30]);
        writesRd = 1'b1;
        legal    = (funct7 == 7'b0000000) ||
                   (funct7 == 7'b0100000 && (funct3 == 3'b000 || funct3 == 3'b101));
      end
      pipelineTypes::opcOpImm: begin
        aluOp    = functToAlu(funct3, inst[30] && funct3 == 3'b101); // no subi
        aluSrc   = pipelineTypes::srcImm;
        immType  = pipelineTypes::immI;
        writesRd = 1'b1;
        if (funct3 == 3'b001) begin
          legal = (funct7 == 7'b0000000);
        end else if (funct3 == 3'b101) begin
          legal = (funct7 == 7'b0000000) || (funct7 == 7'b0100000);
        end
      end
      pipelineTypes::opcLoad: begin
        aluOp    = pipelineTypes::aluAdd;
        aluSrc   = pipelineTypes::srcImm;
        immType  = pipelineTypes::immI;
        isLoad   = 1'b1;
        writesRd = 1'b1;
        legal    = (funct3 != 3'b011) && (funct3 != 3'b110) && (funct3 != 3'b111);
      end
      pipelineTypes::opcStore: begin
        aluOp   = pipelineTypes::aluAdd;
        aluSrc  = pipelineTypes::srcImm;
        immType = pipelineTypes::immS;
        isStore = 1'b1;
        legal   = (funct3 < 3'b011); // sb, sh, sw
      end
      pipelineTypes::opcBranch: begin
        aluOp    = (funct3[2:1] == 2'b00) ? pipelineTypes::aluSub :
                   (funct3[2:1] == 2'b10) ? pipelineTypes::aluSlt : pipelineTypes::aluSltu;
        immType  = pipelineTypes::immB;
        isBranch = 1'b1;
        legal    = (funct3[2:1] != 2'b01);
      end
      default: legal = 1'b0;
    endcase
    // an illegal word carries no control at all
    if (!legal) begin
      aluOp    = pipelineTypes::aluNone;
      aluSrc   = pipelineTypes::srcReg;
      immType  = pipelineTypes::immNone;
      isLoad   = 1'b0;
      isStore  = 1'b0;
      isBranch = 1'b0;
      isJump   = 1'b0;
      writesRd = 1'b0;
    end
  end

  assign isIllegal = !legal;

  always_comb begin
    case (immType)
      pipelineTypes::immI: imm = {{20{inst[31]}}, inst[31:20]};
      pipelineTypes::immS: imm = {{20{inst[31]}}, inst[31:25], inst[11:7]};
      pipelineTypes::immB: imm = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};
      pipelineTypes::immU: imm = {inst[31:12], 12'b0};
      pipelineTypes::immJ: imm = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
      default:             imm = '0;
    endcase
  end

endmodule

// File: source/registerFile.sv
// register file of 32 x 32 bits with two combinational reads and one write port
`timescale 1ns/1ps

module registerFile (
  input  logic                  clk,
  input  logic                  rstN,
  input  basicTypes::RegAddr    rs1Addr,
  input  basicTypes::RegAddr    rs2Addr,
  output basicTypes::BasicData  rs1Data,
  output basicTypes::BasicData  rs2Data,
  input  logic                  wbEnable,
  input  basicTypes::RegAddr    wbAddr,
  input  basicTypes::BasicData  wbData
);

  basicTypes::BasicData regs [1:31]; // x0 has no storage

  // write-through so decode sees a same-cycle writeback
  function automatic basicTypes::BasicData readPort(input basicTypes::RegAddr addr);
    if (addr == '0) begin
      readPort = '0;
    end else if (wbEnable && wbAddr == addr) begin
      readPort = wbData;
    end else begin
      readPort = regs[addr];
    end
  endfunction

  always_comb begin
    rs1Data = readPort(rs1Addr);
    rs2Data = readPort(rs2Addr);
  end

  always_ff @(posedge clk) begin
    if (!rstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEnable && wbAddr != '0) begin
      regs[wbAddr] <= wbData;
    end
  end

endmodule

// File: source/decodeStage.sv
// decodeStage: queue pop, operand read and execute pipeline register
`timescale 1ns/1ps

module decodeStage (
  input  logic                  clk,
  input  logic                  rstN,
  input  logic                  stall,
  input  logic                  redirectValid,
  input  logic                  headValid,
  input  basicTypes::Addr       headPc,
  input  basicTypes::Inst       headInst,
  output logic                  pop,
  output basicTypes::RegAddr    rs1Addr,
  output basicTypes::RegAddr    rs2Addr,
  input  basicTypes::BasicData  rs1Data,
  input  basicTypes::BasicData  rs2Data,
  output logic                  exValid,
  output basicTypes::Addr       exPc,
  output basicTypes::BasicData  exRs1Data,
  output basicTypes::BasicData  exRs2Data,
  output basicTypes::RegAddr    exRdAddr,
  output basicTypes::BasicData  exImm,
  output pipelineTypes::AluOp   exAluOp,
  output pipelineTypes::AluSrc  exAluSrc,
  output logic                  exIsLoad,
  output logic                  exIsStore,
  output logic                  exIsBranch,
  output logic                  exIsJump,
  output logic                  exWritesRd,
  output logic                  exIsIllegal
);

  basicTypes::RegAddr   rdAddr;
  basicTypes::BasicData imm;
  pipelineTypes::AluOp  aluOp;
  pipelineTypes::AluSrc aluSrc;
  logic                 isLoad;
  logic                 isStore;
  logic                 isBranch;
  logic                 isJump;
  logic                 writesRd;
  logic                 isIllegal;

  decoder decoder (
    .inst      (headInst),
    .rs1Addr   (rs1Addr),
    .rs2Addr   (rs2Addr),
    .rdAddr    (rdAddr),
    .imm       (imm),
    .aluOp     (aluOp),
    .aluSrc    (aluSrc),
    .isLoad    (isLoad),
    .isStore   (isStore),
    .isBranch  (isBranch),
    .isJump    (isJump),
    .writesRd  (writesRd),
    .isIllegal (isIllegal)
  );

  assign pop = headValid && !stall && !redirectValid;

  // redirect beats stall, stall holds, otherwise follow pop
  always_ff @(posedge clk) begin
    if (!rstN || redirectValid) begin
      exValid <= 1'b0;
    end else if (!stall) begin
      exValid <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (pop) begin
      exPc        <= headPc;
      exRs1Data   <= rs1Data;
      exRs2Data   <= rs2Data;
      exRdAddr    <= rdAddr;
      exImm       <= imm;
      exAluOp     <= aluOp;
      exAluSrc    <= aluSrc;
      exIsLoad    <= isLoad;
      exIsStore   <= isStore;
      exIsBranch  <= isBranch;
      exIsJump    <= isJump;
      exWritesRd  <= writesRd;
      exIsIllegal <= isIllegal;
    end
  end

endmodule

// File: source/decodeFrontTop.sv
// decodeFrontTop: fetch, instruction queue, register file and decode stage
`timescale 1ns/1ps

module decodeFrontTop (
  input  logic                  clk,
  input  logic                  rstN,
  output basicTypes::Addr       imemAddr,
  input  basicTypes::Inst       imemData,
  input  logic                  stall,
  input  logic                  redirectValid,
  input  basicTypes::Addr       redirectPc,
  input  logic                  wbEnable,
  input  basicTypes::RegAddr    wbAddr,
  input  basicTypes::BasicData  wbData,
  output logic                  exValid,
  output basicTypes::Addr       exPc,
  output basicTypes::BasicData  exRs1Data,
  output basicTypes::BasicData  exRs2Data,
  output basicTypes::RegAddr    exRdAddr,
  output basicTypes::BasicData  exImm,
  output pipelineTypes::AluOp   exAluOp,
  output pipelineTypes::AluSrc  exAluSrc,
  output logic                  exIsLoad,
  output logic                  exIsStore,
  output logic                  exIsBranch,
  output logic                  exIsJump,
  output logic                  exWritesRd,
  output logic                  exIsIllegal
);

  logic                 pushValid;
  basicTypes::Addr      pushPc;
  basicTypes::Inst      pushInst;
  pipelineTypes::Credit creditReturn;
  logic                 headValid;
  basicTypes::Addr      headPc;
  basicTypes::Inst      headInst;
  logic                 pop;
  basicTypes::RegAddr   rs1Addr;
  basicTypes::RegAddr   rs2Addr;
  basicTypes::BasicData rs1Data;
  basicTypes::BasicData rs2Data;

  fetchUnit fetchUnit (
    .clk           (clk),
    .rstN          (rstN),
    .redirectValid (redirectValid),
    .redirectPc    (redirectPc),
    .imemAddr      (imemAddr),
    .imemData      (imemData),
    .creditReturn  (creditReturn),
    .pushValid     (pushValid),
    .pushPc        (pushPc),
    .pushInst      (pushInst)
  );

  instQueue instQueue (
    .clk           (clk),
    .rstN          (rstN),
    .redirectValid (redirectValid),
    .pushValid     (pushValid),
    .pushPc        (pushPc),
    .pushInst      (pushInst),
    .pop           (pop),
    .creditReturn  (creditReturn),
    .headValid     (headValid),
    .headPc        (headPc),
    .headInst      (headInst)
  );

  registerFile registerFile (
    .clk      (clk),
    .rstN     (rstN),
    .rs1Addr  (rs1Addr),
    .rs2Addr  (rs2Addr),
    .rs1Data  (rs1Data),
    .rs2Data  (rs2Data),
    .wbEnable (wbEnable),
    .wbAddr   (wbAddr),
    .wbData   (wbData)
  );

  decodeStage decodeStage (
    .clk           (clk),
    .rstN          (rstN),
    .stall         (stall),
    .redirectValid (redirectValid),
    .headValid     (headValid),
    .headPc        (headPc),
    .headInst      (headInst),
    .pop           (pop),
    .rs1Addr       (rs1Addr),
    .rs2Addr       (rs2Addr),
    .rs1Data       (rs1Data),
    .rs2Data       (rs2Data),
    .exValid       (exValid),
    .exPc          (exPc),
    .exRs1Data     (exRs1Data),
    .exRs2Data     (exRs2Data),
    .exRdAddr      (exRdAddr),
    .exImm         (exImm),
    .exAluOp       (exAluOp),
    .exAluSrc      (exAluSrc),
    .exIsLoad      (exIsLoad),
    .exIsStore     (exIsStore),
    .exIsBranch    (exIsBranch),
    .exIsJump      (exIsJump),
    .exWritesRd    (exWritesRd),
    .exIsIllegal   (exIsIllegal)
  );

endmodule

// File: verification/decodeFrontTb.sv
// testbench with random program, stimulus, reference decode and fetch models, checks and watchdog
`timescale 1ns/1ps

module decodeFrontTb;

  localparam int clkPeriod     = 40;
  localparam int resetCycles   = 8;
  localparam int numCycles     = 2500;
  localparam int freeRunCycles = 300; // no stall or redirect before this
  localparam int randomSeed    = 32934;

  logic                 clk;
  logic                 rstN;
  basicTypes::Addr      imemAddr;
  basicTypes::Inst      imemData;
  logic                 stall;
  logic                 redirectValid;
  basicTypes::Addr      redirectPc;
  logic                 wbEnable;
  basicTypes::RegAddr   wbAddr;
  basicTypes::BasicData wbData;
  logic                 exValid;
  basicTypes::Addr      exPc;
  basicTypes::BasicData exRs1Data;
  basicTypes::BasicData exRs2Data;
  basicTypes::RegAddr   exRdAddr;
  basicTypes::BasicData exImm;
  pipelineTypes::AluOp  exAluOp;
  pipelineTypes::AluSrc exAluSrc;
  logic                 exIsLoad;
  logic                 exIsStore;
  logic                 exIsBranch;
  logic                 exIsJump;
  logic                 exWritesRd;
  logic                 exIsIllegal;
  logic [5:0]           exFlags;
  logic [31:0]          exCtrl;

  basicTypes::Inst      progMem   [64];
  basicTypes::BasicData modelRegs [32];
  basicTypes::Addr      expPc;
  basicTypes::Addr      targetAtEdge;
  logic                 stallAtEdge;
  logic                 redirectAtEdge;
  logic                 prevValid;
  basicTypes::Addr      prevPc;
  basicTypes::BasicData prevRs1;
  basicTypes::BasicData prevRs2;
  basicTypes::BasicData prevImm;
  logic [31:0]          prevCtrl;
  basicTypes::Addr      fetchPc;
  int                   fetchCredits;
  int                   queueCount;
  logic                 popAtEdge;
  int                   stallLeft;
  int                   entryCount;
  int                   illegalCount;

  assign imemData = progMem[imemAddr[7:2]]; // memory answers combinationally
  assign exFlags  = {exIsLoad, exIsStore, exIsBranch, exIsJump, exWritesRd, exIsIllegal};
  assign exCtrl   = {16'd0, exRdAddr, exAluOp, exAluSrc, exFlags};

  decodeFrontTop UUT (
    .clk           (clk),
    .rstN          (rstN),
    .imemAddr      (imemAddr),
    .imemData      (imemData),
    .stall         (stall),
    .redirectValid (redirectValid),
    .redirectPc    (redirectPc),
    .wbEnable      (wbEnable),
    .wbAddr        (wbAddr),
    .wbData        (wbData),
    .exValid       (exValid),
    .exPc          (exPc),
    .exRs1Data     (exRs1Data),
    .exRs2Data     (exRs2Data),
    .exRdAddr      (exRdAddr),
    .exImm         (exImm),
    .exAluOp       (exAluOp),
    .exAluSrc      (exAluSrc),
    .exIsLoad      (exIsLoad),
    .exIsStore     (exIsStore),
    .exIsBranch    (exIsBranch),
    .exIsJump      (exIsJump),
    .exWritesRd    (exWritesRd),
    .exIsIllegal   (exIsIllegal)
  );

  initial begin
    clk = 1'b0;
    forever #(clkPeriod / 2) clk = ~clk;
  end

  initial begin
    #((numCycles + 500 + resetCycles) * clkPeriod);
    $display("run timed out after %0d cycles without finishing", numCycles + 500);
    $display("TESTBENCH FAILED");
    $fatal(1, "watchdog expired");
  end

  task automatic checkEqual(input logic [31:0] actual, input logic [31:0] expected,
                            input string what);
    if (actual !== expected) begin
      $display("ERROR at %0t ns: %s, got %h, expected %h", $time, what, actual, expected);
      $display("TESTBENCH FAILED");
      $fatal(1, "mismatch");
    end
  endtask

  // random words from the supported set with roughly one in eight illegal
  function automatic basicTypes::Inst randomWord();
    basicTypes::Inst w;
    int              sel;
    w = $urandom;
    if ($urandom_range(0, 7) == 0) begin
      sel = $urandom_range(0, 3);
      case (sel)
        0:       w[6:0] = 7'b1110011; // system
        1:       w[6:0] = 7'b0001111; // fence
        2:       w[6:0] = 7'b1100111; // jalr is not supported here
        default: begin
          w[6:0]   = 7'b0110011;
          w[31:25] = 7'b0000001; // multiply extension
        end
      endcase
      return w;
    end
    sel = $urandom_range(0, 7);
    case (sel)
      0: w[6:0] = 7'b0110111;
      1: w[6:0] = 7'b0010111;
      2: w[6:0] = 7'b1101111;
      3: begin
        w[6:0]   = 7'b0110011;
        w[31:25] = ((w[14:12] == 3'd0 || w[14:12] == 3'd5) && w[30]) ? 7'h20 : 7'h00;
      end
      4: begin
        w[6:0] = 7'b0010011;
        if (w[14:12] == 3'd1) begin
          w[31:25] = 7'h00;
        end else if (w[14:12] == 3'd5) begin
          w[31:25] = w[30] ? 7'h20 : 7'h00;
        end
      end
      5: begin
        w[6:0]   = 7'b0000011;
        sel      = $urandom_range(0, 4);
        w[14:12] = 3'((sel > 2) ? sel + 1 : sel); // lb lh lw lbu lhu
      end
      6: begin
        w[6:0]   = 7'b0100011;
        w[14:12] = 3'($urandom_range(0, 2));
      end
      default: begin
        w[6:0]   = 7'b1100011;
        sel      = $urandom_range(0, 5);
        w[14:12] = 3'((sel > 1) ? sel + 2 : sel); // skips the two reserved codes
      end
    endcase
    return w;
  endfunction

  function automatic pipelineTypes::AluOp aluForFunct(input logic [2:0] f3, input logic alt);
    case (f3)
      3'd0:    return alt ? pipelineTypes::aluSub : pipelineTypes::aluAdd;
      3'd1:    return pipelineTypes::aluSll;
      3'd2:    return pipelineTypes::aluSlt;
      3'd3:    return pipelineTypes::aluSltu;
      3'd4:    return pipelineTypes::aluXor;
      3'd5:    return alt ? pipelineTypes::aluSra : pipelineTypes::aluSrl;
      3'd6:    return pipelineTypes::aluOr;
      default: return pipelineTypes::aluAnd;
    endcase
  endfunction

  // reference decode with flags ordered load store branch jump writesRd illegal
  task automatic predictDecode(input basicTypes::Inst w, output pipelineTypes::AluOp op,
                               output pipelineTypes::AluSrc src,
                               output basicTypes::BasicData imm, output logic [5:0] flags);
    logic [2:0] f3;
    logic [6:0] f7;
    logic       legal;
    f3    = w[14:12];
    f7    = w[31:25];
    op    = pipelineTypes::aluAdd;
    src   = pipelineTypes::srcImm;
    imm   = {{20{w[31]}}, w[31:20]};
    flags = 6'b000010;
    legal = 1'b1;
    case (w[6:0])
      7'b0110111: begin
        op  = pipelineTypes::aluPassB;
        imm = {w[31:12], 12'h000};
      end
      7'b0010111: imm = {w[31:12], 12'h000};
      7'b1101111: begin
        imm   = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        flags = 6'b000110;
      end
      7'b0110011: begin
        op    = aluForFunct(f3, w[30]);
        src   = pipelineTypes::srcReg;
        imm   = '0;
        legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
      end
      7'b0010011: begin
        op    = aluForFunct(f3, f3 == 3'd5 && w[30]);
        legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
      end
      7'b0000011: begin
        flags = 6'b100010;
        legal = (f3 != 3'd3) && (f3 < 3'd6);
      end
      7'b0100011: begin
        imm   = {{20{w[31]}}, w[31:25], w[11:7]};
        flags = 6'b010000;
        legal = (f3 <= 3'd2);
      end
      7'b1100011: begin
        op    = (f3 < 3'd2) ? pipelineTypes::aluSub :
                (f3 < 3'd6) ? pipelineTypes::aluSlt : pipelineTypes::aluSltu;
        src   = pipelineTypes::srcReg;
        imm   = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        flags = 6'b001000;
        legal = (f3 != 3'd2) && (f3 != 3'd3);
      end
      default: legal = 1'b0;
    endcase
    if (!legal) begin
      op    = pipelineTypes::aluNone;
      src   = pipelineTypes::srcReg;
      imm   = '0;
      flags = 6'b000001;
    end
  endtask

  // fetch pc and queue occupancy as the credit rules predict them
  task automatic advanceFetchModel();
    logic pushed;
    pushed    = (fetchCredits != 0) && !redirectAtEdge;
    popAtEdge = (queueCount != 0) && !stallAtEdge && !redirectAtEdge;
    if (redirectAtEdge) begin
      fetchPc      = targetAtEdge;
      fetchCredits = fetchCredits + queueCount; // flushed entries come back as credits
      queueCount   = 0;
    end else begin
      fetchPc      = pushed ? fetchPc + 32'd4 : fetchPc;
      fetchCredits = fetchCredits - int'(pushed) + int'(popAtEdge);
      queueCount   = queueCount + int'(pushed) - int'(popAtEdge);
    end
  endtask

  task automatic checkEntry();
    basicTypes::Inst      w;
    pipelineTypes::AluOp  op;
    pipelineTypes::AluSrc src;
    basicTypes::BasicData imm;
    logic [5:0]           flags;
    w = progMem[expPc[7:2]];
    predictDecode(w, op, src, imm, flags);
    checkEqual(exPc, expPc, "exPc out of sequence");
    checkEqual(32'(exRdAddr), 32'(w[11:7]), "exRdAddr");
    checkEqual(exImm, imm, "exImm");
    checkEqual(32'(exAluOp), 32'(op), "exAluOp");
    checkEqual(32'(exAluSrc), 32'(src), "exAluSrc");
    checkEqual(32'(exFlags), 32'(flags), "control flags");
    checkEqual(exRs1Data, modelRegs[w[19:15]], "exRs1Data");
    checkEqual(exRs2Data, modelRegs[w[24:20]], "exRs2Data");
    entryCount++;
    if (flags[0]) begin
      illegalCount++;
    end
    expPc = expPc + 32'd4;
  endtask

  task automatic driveInputs(input int cyc);
    int              pick;
    basicTypes::Inst nextWord;
    nextWord = progMem[expPc[7:2]];
    if (cyc >= freeRunCycles && stallLeft == 0 && $urandom_range(0, 24) == 0) begin
      stallLeft = $urandom_range(1, 20);
    end
    stall <= (stallLeft != 0);
    if (stallLeft != 0) begin
      stallLeft--;
    end
    redirectValid <= (cyc >= freeRunCycles) && ($urandom_range(0, 39) == 0);
    redirectPc    <= {24'd0, 6'($urandom_range(0, 63)), 2'b00};
    // aim some writebacks at the operands of the next word to decode
    pick     = $urandom_range(0, 7);
    wbEnable <= 1'($urandom_range(0, 1));
    wbAddr   <= (pick == 0) ? 5'd0 : (pick < 3) ? nextWord[19:15] :
                (pick == 3) ? nextWord[24:20] : 5'($urandom);
    wbData   <= $urandom;
  endtask

  task automatic checkOutputs();
    checkEqual(imemAddr, fetchPc, "imemAddr off the fetch pc");
    if (redirectAtEdge) begin
      checkEqual(32'(exValid), 32'd0, "exValid not cleared by redirect");
      expPc = targetAtEdge;
    end else if (stallAtEdge) begin
      checkEqual(32'(exValid), 32'(prevValid), "exValid moved during stall");
      if (prevValid) begin
        checkEqual(exPc, prevPc, "exPc moved during stall");
        checkEqual(exRs1Data, prevRs1, "exRs1Data moved during stall");
        checkEqual(exRs2Data, prevRs2, "exRs2Data moved during stall");
        checkEqual(exImm, prevImm, "exImm moved during stall");
        checkEqual(exCtrl, prevCtrl, "ex control moved during stall");
      end
    end else begin
      checkEqual(32'(exValid), 32'(popAtEdge), "exValid does not follow the queue pop");
      if (exValid) begin
        checkEntry();
      end
    end
    prevValid = exValid;
    prevPc    = exPc;
    prevRs1   = exRs1Data;
    prevRs2   = exRs2Data;
    prevImm   = exImm;
    prevCtrl  = exCtrl;
  endtask

  initial begin
    void'($urandom(randomSeed));
    rstN          = 1'b0;
    stall         = 1'b0;
    redirectValid = 1'b0;
    redirectPc    = '0;
    wbEnable      = 1'b0;
    wbAddr        = '0;
    wbData        = '0;
    expPc         = '0;
    fetchPc       = '0;
    fetchCredits  = pipelineTypes::queueDepth;
    queueCount    = 0;
    popAtEdge     = 1'b0;
    prevValid     = 1'b0;
    stallLeft     = 0;
    entryCount    = 0;
    illegalCount  = 0;
    for (int i = 0; i < 64; i++) begin
      progMem[i] = randomWord();
    end
    for (int i = 0; i < 32; i++) begin
      modelRegs[i] = '0;
    end
    repeat (resetCycles) @(posedge clk);
    rstN <= 1'b1;
    for (int cyc = 0; cyc < numCycles; cyc++) begin
      @(posedge clk);
      if (wbEnable && wbAddr != 5'd0) begin
        modelRegs[wbAddr] = wbData; // same write the register file takes at this edge
      end
      stallAtEdge    = stall;
      redirectAtEdge = redirectValid;
      targetAtEdge   = redirectPc;
      advanceFetchModel();
      driveInputs(cyc);
      @(negedge clk);
      checkOutputs();
    end
    $display("%0d words decoded, %0d of them illegal", entryCount, illegalCount);
    if (entryCount > 500 && illegalCount > 0) begin
      $display("TESTBENCH PASSED");
      $finish;
    end else begin
      $display("too few words or no illegal word reached the execute register");
      $display("TESTBENCH FAILED");
      $fatal(1, "coverage too low");
    end
  end

endmodule

// File: build.f
source/basicTypes.sv
source/pipelineTypes.sv
source/fetchUnit.sv
source/instQueue.sv
source/decoder.sv
source/registerFile.sv
source/decodeStage.sv
source/decodeFrontTop.sv
verification/decodeFrontTb.sv

// File: build.sh
#!/usr/bin/env bash
# compile and run the decode front testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module decodeFrontTb -f build.f -o decodeFrontSim

# the simulator exit status is not trusted, the log decides
./obj_dir/decodeFrontSim 2>&1 | tee sim.log

if grep -q "TESTBENCH FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "TESTBENCH PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"
